//--- build.f
rtl/erx_pkg.sv
rtl/erx_frame_ctrl.sv
rtl/erx_sampler.sv
rtl/erx_unpack.sv
rtl/erx_fifo.sv
rtl/erx_regs.sv
rtl/erx_rx.sv
sim/tb_clkgen.sv
sim/erx_checker.sv
sim/tb_erx.sv

//--- rtl/erx_fifo.sv
// packet fifo: circular buffer with valid/ready output, wait level and drop flag
module erx_fifo
   import erx_pkg::*;
#(
   parameter int FIFO_DEPTH = 4,
   parameter int WAIT_LEVEL = 3
)
(
   input  logic          rx_lclk,
   input  logic          erx_io_nreset,
   input  logic          pkt_push,
   input  erx_packet_u   pkt,
   input  logic          pkt_burst_in,
   output logic          pkt_valid,
   input  logic          pkt_ready,
   output logic [PW-1:0] pkt_data,
   output logic          pkt_burst,
   output logic          rx_wr_wait,     // pushback to transmitter
   output logic          drop            // overflow pulse
);

   localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int LW = $clog2(FIFO_DEPTH + 1);

   logic [PW-1:0] mem       [FIFO_DEPTH];
   logic          burst_mem [FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [LW-1:0] level;
   logic          full;
   logic          pop;
   logic          wr_en;

   // pointer step with wrap, depth need not be a power of two
   function automatic logic [AW-1:0] bump(input logic [AW-1:0] p);
      return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full  = (level == LW'(FIFO_DEPTH));
   assign pop   = pkt_valid & pkt_ready;
   assign wr_en = pkt_push & (~full | pop);   // a pop frees the slot same cycle

   always_ff @(posedge rx_lclk)
   begin
      if (wr_en)
      begin
         mem[wr_ptr]       <= pkt.raw;
         burst_mem[wr_ptr] <= pkt_burst_in;
      end
   end

   //######################################
   //# pointers and level
   //######################################
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
         drop   <= 1'b0;
      end
      else
      begin
         drop <= pkt_push & ~wr_en;   // packet lost
         if (wr_en)
            wr_ptr <= bump(wr_ptr);
         if (pop)
            rd_ptr <= bump(rd_ptr);
         case ({wr_en, pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   // head entry drives the output, steady until popped
   assign pkt_valid  = (level != '0);
   assign pkt_data   = mem[rd_ptr];
   assign pkt_burst  = burst_mem[rd_ptr];
   assign rx_wr_wait = (level >= LW'(WAIT_LEVEL));

endmodule

//--- rtl/erx_frame_ctrl.sv
// frame control: word pointer inside a frame, burst detect and access strobe
module erx_frame_ctrl (
   input  logic       rx_lclk,
   input  logic       erx_io_nreset,
   input  logic       enable,          // from config register
   input  logic       frame_q,         // registered frame from sampler
   output logic [6:0] pointer,         // one-hot slot select
   output logic       access,          // packet complete strobe
   output logic       burst            // burst continuation flag
);

   logic burst_detect;

   //######################################
   //# word pointer
   //######################################
   // idle or disabled parks the pointer on slot 0
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         pointer <= 7'b000_0001;
      end
      else if (!enable || !frame_q)
      begin
         pointer <= 7'b000_0001;       // new frame
      end
      else if (pointer[6])
      begin
         pointer <= 7'b000_1000;       // next beat reuses header slots 0-2
      end
      else
      begin
         pointer <= {pointer[5:0], 1'b0};  // mid frame
      end
   end

   //######################################
   //# access strobe and burst detect
   //######################################
   // slot 6 lands one edge after pointer bit6, so strobe then
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         access       <= 1'b0;
         burst_detect <= 1'b0;
      end
      else
      begin
         access <= pointer[6] & enable;
         if (!enable || !frame_q)
            burst_detect <= 1'b0;      // frame over
         else if (access)
            burst_detect <= 1'b1;      // frame kept going past a packet
      end
   end

   assign burst = burst_detect;        // lags one packet, first beat stays low

endmodule

//--- rtl/erx_pkg.sv
// link receiver shared definitions: packet views, register map and widths
package erx_pkg;

   localparam int PW = 104;              // packet width
   localparam int SW = 112;              // sample width, seven 16 bit words

   //######################################
   //# packet, one word read two ways
   //######################################
   typedef union packed {
      logic [PW-1:0] raw;                // fifo and output view
      struct packed {
         logic [31:0] srcaddr;           // [103:72]
         logic [31:0] data;              // [71:40]
         logic [31:0] dstaddr;           // [39:8]
         logic [3:0]  ctrlmode;          // [7:4]
         logic [1:0]  datamode;          // [3:2]
         logic        write;             // [1]
         logic        access;            // [0]
      } f;                               // field view
   } erx_packet_u;

   //######################################
   //# axi4-lite register map
   //######################################
   localparam logic [31:0] REG_CFG     = 32'h0000_0000;  // bit0 enable, bit1 load pulse
   localparam logic [31:0] REG_TAPLO   = 32'h0000_0004;  // taps 31:0
   localparam logic [31:0] REG_TAPHI   = 32'h0000_0008;  // taps 44:32
   localparam logic [31:0] REG_RXCNT   = 32'h0000_000C;  // packets seen, ro
   localparam logic [31:0] REG_DROPCNT = 32'h0000_0010;  // packets lost, ro

   localparam logic [1:0]  RESP_OKAY   = 2'b00;

endpackage

//--- rtl/erx_regs.sv
// register slave: axi4-lite access to enable, delay taps and packet counters
module erx_regs
   import erx_pkg::*;
#(
   parameter int CNT_W = 16
)
(
   input  logic        rx_lclk,
   input  logic        erx_io_nreset,
   input  logic [31:0] awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [31:0] araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready,
   input  logic        pkt_push,     // packet count
   input  logic        drop,         // drop count
   output logic        enable,
   output logic [44:0] idelay_value,
   output logic        load_taps
);

   logic [31:0]      tap_lo;
   logic [12:0]      tap_hi;
   logic [CNT_W-1:0] rx_cnt;
   logic [CNT_W-1:0] drop_cnt;
   logic [31:0]      taplo_next;
   logic [31:0]      taphi_next;
   logic [31:0]      rd_mux;
   logic             wr_hs;
   logic             rd_hs;

   // byte lanes from wstrb over the old value
   function automatic logic [31:0] wmerge(input logic [31:0] old_v,
                                          input logic [31:0] new_v,
                                          input logic [3:0]  strb);
      logic [31:0] res;
      res = old_v;
      for (int b = 0; b < 4; b++)
      begin
         if (strb[b])
            res[b*8 +: 8] = new_v[b*8 +: 8];
      end
      return res;
   endfunction

   assign taplo_next   = wmerge(tap_lo, wdata, wstrb);
   assign taphi_next   = wmerge({19'b0, tap_hi}, wdata, wstrb);
   assign idelay_value = {tap_hi, tap_lo};
   assign wr_hs        = awvalid & awready & wvalid & wready;
   assign rd_hs        = arvalid & arready;
   assign bresp        = RESP_OKAY;
   assign rresp        = RESP_OKAY;

   //######################################
   //# write channel
   //######################################
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         awready   <= 1'b0;
         wready    <= 1'b0;
         bvalid    <= 1'b0;
         enable    <= 1'b0;
         load_taps <= 1'b0;
         tap_lo    <= '0;
         tap_hi    <= '0;
      end
      else
      begin
         load_taps <= 1'b0;                    // single cycle pulse
         // take address and data together, one at a time
         awready <= awvalid & wvalid & ~awready & ~bvalid;
         wready  <= awvalid & wvalid & ~wready & ~bvalid;
         if (wr_hs)
         begin
            bvalid <= 1'b1;
            case (awaddr)
               REG_CFG:
               begin
                  if (wstrb[0])
                  begin
                     enable    <= wdata[0];
                     load_taps <= wdata[1];
                  end
               end
               REG_TAPLO: tap_lo <= taplo_next;
               REG_TAPHI: tap_hi <= taphi_next[12:0];
               default:   ;                     // unmapped or read-only
            endcase
         end
         else if (bready)
            bvalid <= 1'b0;
      end
   end

   //######################################
   //# read channel and counters
   //######################################
   always_comb
   begin
      case (araddr)
         REG_CFG:     rd_mux = {31'b0, enable};
         REG_TAPLO:   rd_mux = tap_lo;
         REG_TAPHI:   rd_mux = {19'b0, tap_hi};
         REG_RXCNT:   rd_mux = {{(32-CNT_W){1'b0}}, rx_cnt};
         REG_DROPCNT: rd_mux = {{(32-CNT_W){1'b0}}, drop_cnt};
         default:     rd_mux = '0;
      endcase
   end

   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         arready  <= 1'b0;
         rvalid   <= 1'b0;
         rx_cnt   <= '0;
         drop_cnt <= '0;
      end
      else
      begin
         arready <= arvalid & ~arready & ~rvalid;
         if (rd_hs)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
         if (pkt_push && !(&rx_cnt))
            rx_cnt <= rx_cnt + 1'b1;          // saturates
         if (drop && !(&drop_cnt))
            drop_cnt <= drop_cnt + 1'b1;
      end
   end

   always_ff @(posedge rx_lclk)
   begin
      if (rd_hs)
         rdata <= rd_mux;                     // held until next read
   end

endmodule

//--- rtl/erx_rx.sv
// link receiver top: framing, sampling, unpack, packet fifo and register slave
module erx_rx
   import erx_pkg::*;
#(
   parameter int FIFO_DEPTH = 4,
   parameter int WAIT_LEVEL = 3,
   parameter int CNT_W      = 16
)
(
   input  logic          rx_lclk,
   input  logic          erx_io_nreset,
   input  logic          rx_frame,
   input  logic [15:0]   rx_word,
   output logic          pkt_valid,
   input  logic          pkt_ready,
   output logic [PW-1:0] pkt_data,
   output logic          pkt_burst,
   output logic          rx_wr_wait,
   output logic [44:0]   idelay_value,
   output logic          load_taps,
   input  logic [31:0]   awaddr,
   input  logic          awvalid,
   output logic          awready,
   input  logic [31:0]   wdata,
   input  logic [3:0]    wstrb,
   input  logic          wvalid,
   output logic          wready,
   output logic [1:0]    bresp,
   output logic          bvalid,
   input  logic          bready,
   input  logic [31:0]   araddr,
   input  logic          arvalid,
   output logic          arready,
   output logic [31:0]   rdata,
   output logic [1:0]    rresp,
   output logic          rvalid,
   input  logic          rready
);

   logic          enable;
   logic          frame_q;
   logic [6:0]    pointer;
   logic          access;
   logic          burst;
   logic [SW-1:0] sample;
   erx_packet_u   pkt;
   logic          unp_burst;
   logic          pkt_push;
   logic          drop;

   erx_frame_ctrl u_frame_ctrl (
      .rx_lclk, .erx_io_nreset, .enable, .frame_q, .pointer, .access, .burst
   );

   erx_sampler u_sampler (
      .rx_lclk, .erx_io_nreset, .rx_frame, .rx_word, .pointer, .frame_q, .sample
   );

   erx_unpack u_unpack (
      .rx_lclk, .erx_io_nreset, .access, .burst, .sample, .pkt,
      .pkt_burst (unp_burst),
      .pkt_push
   );

   erx_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .WAIT_LEVEL(WAIT_LEVEL)) u_fifo (
      .rx_lclk, .erx_io_nreset, .pkt_push, .pkt,
      .pkt_burst_in (unp_burst),
      .pkt_valid, .pkt_ready, .pkt_data, .pkt_burst, .rx_wr_wait, .drop
   );

   erx_regs #(.CNT_W(CNT_W)) u_regs (
      .rx_lclk, .erx_io_nreset,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
      .rdata, .rresp, .rvalid, .rready,
      .pkt_push, .drop, .enable, .idelay_value, .load_taps
   );

endmodule

//--- rtl/erx_sampler.sv
// input sampler: registers the link word and frame, fills the 112 bit sample
module erx_sampler
   import erx_pkg::*;
(
   input  logic          rx_lclk,
   input  logic          erx_io_nreset,
   input  logic          rx_frame,       // ddr sampled frame
   input  logic [15:0]   rx_word,        // ddr sampled word
   input  logic [6:0]    pointer,        // slot select
   output logic          frame_q,
   output logic [SW-1:0] sample
);

   logic [15:0] word_q;

   // input stage for timing
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         frame_q <= 1'b0;
      else
         frame_q <= rx_frame;
   end

   always_ff @(posedge rx_lclk)
   begin
      word_q <= rx_word;               // link payload
   end

   //######################################
   //# sample slots
   //######################################
   // slot k takes the word while pointer bit k is set
   always_ff @(posedge rx_lclk)
   begin
      for (int k = 0; k < 7; k++)
      begin
         if (pointer[k])
            sample[k*16 +: 16] <= word_q;
      end
   end

endmodule

//--- rtl/erx_unpack.sv
// unpacker: shuffles the 112 bit sample into the 104 bit packet on access
module erx_unpack
   import erx_pkg::*;
(
   input  logic          rx_lclk,
   input  logic          erx_io_nreset,
   input  logic          access,         // sample complete
   input  logic          burst,          // from burst detect
   input  logic [SW-1:0] sample,
   output erx_packet_u   pkt,
   output logic          pkt_burst,
   output logic          pkt_push        // one cycle per packet
);

   // push strobe trails access by one edge, aligned with pkt
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         pkt_push <= 1'b0;
      else
         pkt_push <= access;
   end

   //######################################
   //# byte reorder
   //######################################
   // header slots are left alone on burst beats, so fields carry over
   always_ff @(posedge rx_lclk)
   begin
      if (access)
      begin
         pkt_burst         <= burst;
         pkt.f.access      <= sample[40];
         pkt.f.write       <= sample[41];
         pkt.f.datamode    <= sample[43:42];
         pkt.f.ctrlmode    <= sample[15:12];
         // dstaddr straddles five slices, nibbles at both ends
         pkt.f.dstaddr     <= {sample[11:8], sample[23:16], sample[31:24],
                               sample[39:32], sample[47:44]};
         pkt.f.data        <= {sample[55:48], sample[63:56],
                               sample[71:64], sample[79:72]};   // byte swapped
         pkt.f.srcaddr     <= {sample[87:80], sample[95:88],
                               sample[103:96], sample[111:104]}; // byte swapped
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# build the erx testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_erx -o erx_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/erx_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1

//--- sim/erx_checker.sv
// packet checker: compares every accepted output packet with the expected queue
module erx_checker
   import erx_pkg::*;
(
   input logic          rx_lclk,
   input logic          erx_io_nreset,
   input logic          pkt_valid,
   input logic          pkt_ready,
   input logic [PW-1:0] pkt_data,
   input logic          pkt_burst
);

   logic [PW-1:0] exp_q [$];            // expected packets, oldest first
   logic          exp_burst_q [$];
   int            errors    = 0;
   int            got_count = 0;        // packets taken from the dut
   logic          held      = 1'b0;     // stalled last cycle
   logic [PW-1:0] held_data;

   task automatic expect_pkt(input logic [PW-1:0] p, input logic b);
      exp_q.push_back(p);
      exp_burst_q.push_back(b);
   endtask

   function automatic int pending();
      return exp_q.size();
   endfunction

   task automatic check_field(input string name, input logic [31:0] exp_v,
                              input logic [31:0] got_v);
      if (exp_v !== got_v)
      begin
         $display("[FAIL] %s exp %h got %h", name, exp_v, got_v);
         errors++;
      end
   endtask

   //######################################
   //# output monitor
   //######################################
   // mid cycle sample, a valid with ready here transfers on the next edge
   always @(negedge rx_lclk)
   begin : compare
      erx_packet_u e;
      erx_packet_u g;
      logic        eb;
      if (erx_io_nreset)
      begin
         if (held && (pkt_data !== held_data))
         begin
            $display("[FAIL] pkt_data held exp %h got %h", held_data, pkt_data);
            errors++;
         end
         held      = pkt_valid && !pkt_ready;   // head must not move
         held_data = pkt_data;
         if (pkt_valid && pkt_ready)
         begin
            got_count++;
            if (exp_q.size() == 0)
            begin
               $display("a packet came out that was never sent");
               errors++;
            end
            else
            begin
               e.raw = exp_q.pop_front();
               eb    = exp_burst_q.pop_front();
               g.raw = pkt_data;
               check_field("pkt_data.srcaddr", e.f.srcaddr, g.f.srcaddr);
               check_field("pkt_data.data", e.f.data, g.f.data);
               check_field("pkt_data.dstaddr", e.f.dstaddr, g.f.dstaddr);
               check_field("pkt_data.ctrlmode", 32'(e.f.ctrlmode), 32'(g.f.ctrlmode));
               check_field("pkt_data.datamode", 32'(e.f.datamode), 32'(g.f.datamode));
               check_field("pkt_data.write", 32'(e.f.write), 32'(g.f.write));
               check_field("pkt_data.access", 32'(e.f.access), 32'(g.f.access));
               check_field("pkt_burst", 32'(eb), 32'(pkt_burst));
            end
         end
      end
   end

endmodule

//--- sim/tb_clkgen.sv
// testbench clock and reset source for the link receiver
module tb_clkgen #(
   parameter int PERIOD     = 8,       // time units
   parameter int RST_CYCLES = 5
)
(
   output logic rx_lclk,
   output logic erx_io_nreset
);

   initial
   begin
      rx_lclk = 1'b0;
      forever #(PERIOD / 2) rx_lclk = ~rx_lclk;
   end

   // reset low from time 0, released just after an edge
   initial
   begin
      erx_io_nreset = 1'b0;
      repeat (RST_CYCLES) @(posedge rx_lclk);
      #1;
      erx_io_nreset = 1'b1;
   end

endmodule

//--- sim/tb_erx.sv
// testbench top: link frames from a table and register accesses over axi4-lite
module tb_erx
   import erx_pkg::*;
();

   localparam int FIFO_DEPTH = 4;
   localparam int WAIT_LEVEL = 3;
   localparam int CNT_W      = 16;
   localparam int HS_TMO     = 50;         // cycles per handshake
   localparam int DRAIN_TMO  = 400;
   localparam int WATCHDOG   = 20000;      // whole run
   localparam int N_ENT      = 6;
   localparam int N_FLOOD    = 6;          // frames against a stalled output

   logic          rx_lclk;
   logic          erx_io_nreset;
   logic          rx_frame;
   logic [15:0]   rx_word;
   logic          pkt_valid;
   logic          pkt_ready;
   logic [PW-1:0] pkt_data;
   logic          pkt_burst;
   logic          rx_wr_wait;
   logic [44:0]   idelay_value;
   logic          load_taps;
   logic [31:0]   awaddr;
   logic          awvalid;
   logic          awready;
   logic [31:0]   wdata;
   logic [3:0]    wstrb;
   logic          wvalid;
   logic          wready;
   logic [1:0]    bresp;
   logic          bvalid;
   logic          bready;
   logic [31:0]   araddr;
   logic          arvalid;
   logic          arready;
   logic [31:0]   rdata;
   logic [1:0]    rresp;
   logic          rvalid;
   logic          rready;

   //######################################
   //# stimulus table
   //######################################
   // header fields are drawn at run time, extra beats get random payload
   logic [31:0] tab_data  [N_ENT] = '{32'h1122_3344, 32'hDEAD_BEEF, 32'hA5A5_5A5A,
                                      32'h0F0F_F0F0, 32'h0000_0000, 32'h7654_3210};
   logic [31:0] tab_src   [N_ENT] = '{32'h8000_0010, 32'h0000_0004, 32'h1234_5678,
                                      32'hCAFE_0000, 32'hFFFF_FFFF, 32'h0BAD_F00D};
   int          tab_beats [N_ENT] = '{0, 0, 1, 2, 0, 2};           // burst beats
   logic [7:0]  tab_ready [N_ENT] = '{8'hFF, 8'b1010_1010, 8'hFF,
                                      8'b0110_0011, 8'b0001_0001, 8'b1100_1111};

   logic [15:0] frame_words [$];           // next frame, in link order
   logic [31:0] rng_state;
   logic [7:0]  ready_pat = 8'hFF;         // pkt_ready, one bit per cycle
   logic [2:0]  rcyc;
   int          tb_errors = 0;
   int          sent      = 0;             // packets expected out
   int          pushed    = 0;             // packets reaching the fifo
   int          load_cycles = 0;

   tb_clkgen #(.PERIOD(8), .RST_CYCLES(5)) u_clkgen (.rx_lclk, .erx_io_nreset);

   erx_rx #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .WAIT_LEVEL (WAIT_LEVEL),
      .CNT_W      (CNT_W)
   ) u_erx_rx (.*);

   erx_checker u_chk (.rx_lclk, .erx_io_nreset, .pkt_valid, .pkt_ready, .pkt_data,
                      .pkt_burst);

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic next_random(output logic [31:0] v);
      rng_state = xorshift32(rng_state);
      v         = rng_state;
   endtask

   // link byte order, inverse of the receiver reorder
   function automatic logic [SW-1:0] pack_sample(input erx_packet_u p);
      logic [SW-1:0] s;
      s          = '0;
      s[15:12]   = p.f.ctrlmode;
      s[11:8]    = p.f.dstaddr[31:28];     // dstaddr nibble first
      s[23:16]   = p.f.dstaddr[27:20];
      s[31:24]   = p.f.dstaddr[19:12];
      s[39:32]   = p.f.dstaddr[11:4];
      s[40]      = p.f.access;
      s[41]      = p.f.write;
      s[43:42]   = p.f.datamode;
      s[47:44]   = p.f.dstaddr[3:0];
      s[55:48]   = p.f.data[31:24];
      s[63:56]   = p.f.data[23:16];
      s[71:64]   = p.f.data[15:8];
      s[79:72]   = p.f.data[7:0];
      s[87:80]   = p.f.srcaddr[31:24];
      s[95:88]   = p.f.srcaddr[23:16];
      s[103:96]  = p.f.srcaddr[15:8];
      s[111:104] = p.f.srcaddr[7:0];
      return s;
   endfunction

   task automatic random_header(output erx_packet_u p);
      logic [31:0] r;
      p.raw = '0;
      next_random(r);
      p.f.dstaddr = r;
      next_random(r);
      p.f.ctrlmode = r[3:0];
      p.f.datamode = r[5:4];
      p.f.write    = r[6];
      p.f.access   = 1'b1;
   endtask

   // a continuation beat only carries slots 3 to 6
   task automatic queue_words(input erx_packet_u p, input logic cont);
      logic [SW-1:0] s;
      s = pack_sample(p);
      for (int k = (cont ? 3 : 0); k < 7; k++)
         frame_words.push_back(16'(s >> (16 * k)));
   endtask

   task automatic load_entry(input int i);
      erx_packet_u p;
      logic [31:0] r;
      random_header(p);
      p.f.data    = tab_data[i];
      p.f.srcaddr = tab_src[i];
      queue_words(p, 1'b0);
      u_chk.expect_pkt(p.raw, 1'b0);       // burst flag lags one packet
      for (int b = 0; b < tab_beats[i]; b++)
      begin
         next_random(r);
         p.f.data = r;
         next_random(r);
         p.f.srcaddr = r;
         queue_words(p, 1'b1);
         u_chk.expect_pkt(p.raw, 1'b1);
      end
      sent   += 1 + tab_beats[i];
      pushed += 1 + tab_beats[i];
   endtask

   //######################################
   //# link and bus drivers
   //######################################
   task automatic drive_frame();
      foreach (frame_words[i])
      begin
         @(posedge rx_lclk);
         #1;
         rx_frame = 1'b1;
         rx_word  = frame_words[i];
      end
      @(posedge rx_lclk);
      #1;
      rx_frame = 1'b0;
      rx_word  = 16'h0;
      repeat (2) @(posedge rx_lclk);       // idle gap between frames
      frame_words.delete();
   endtask

   task automatic note_timeout(input string what);
      $display("timed out waiting for %s", what);
      tb_errors++;
   endtask

   task automatic check_value(input string name, input logic [63:0] exp_v,
                              input logic [63:0] got_v);
      if (exp_v !== got_v)
      begin
         $display("[FAIL] %s exp %h got %h", name, exp_v, got_v);
         tb_errors++;
      end
   endtask

   task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
      int n;
      @(posedge rx_lclk);
      #1;
      awaddr  = addr;
      awvalid = 1'b1;
      wdata   = data;
      wstrb   = 4'hF;
      wvalid  = 1'b1;
      n = 0;
      @(negedge rx_lclk);
      while (!(awready && wready) && n < HS_TMO)
      begin
         @(negedge rx_lclk);
         n++;
      end
      if (!(awready && wready))
         note_timeout("write address and data ready");
      @(posedge rx_lclk);                  // handshake edge
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      n = 0;
      @(negedge rx_lclk);
      while (!bvalid && n < HS_TMO)
      begin
         @(negedge rx_lclk);
         n++;
      end
      if (!bvalid)
         note_timeout("write response");
      else
         check_value("bresp", 64'h0, 64'(bresp));   // okay
   endtask

   task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
      int n;
      @(posedge rx_lclk);
      #1;
      araddr  = addr;
      arvalid = 1'b1;
      n = 0;
      @(negedge rx_lclk);
      while (!arready && n < HS_TMO)
      begin
         @(negedge rx_lclk);
         n++;
      end
      if (!arready)
         note_timeout("read address ready");
      @(posedge rx_lclk);
      #1;
      arvalid = 1'b0;
      n = 0;
      @(negedge rx_lclk);
      while (!rvalid && n < HS_TMO)
      begin
         @(negedge rx_lclk);
         n++;
      end
      if (!rvalid)
         note_timeout("read data");
      else
         check_value("rresp", 64'h0, 64'(rresp));   // okay
      data = rdata;
   endtask

   task automatic wait_reset();
      int n;
      n = 0;
      @(posedge rx_lclk);
      while (!erx_io_nreset && n < HS_TMO)
      begin
         @(posedge rx_lclk);
         n++;
      end
      if (!erx_io_nreset)
         note_timeout("reset release");
   endtask

   // checker counts at negedge, read here at posedge
   task automatic wait_drained();
      int n;
      n = 0;
      while (u_chk.got_count < sent && n < DRAIN_TMO)
      begin
         @(posedge rx_lclk);
         n++;
      end
      if (u_chk.got_count < sent)
         note_timeout("the output to drain");
   endtask

   task automatic watch_no_valid(input int cycles);
      int seen;
      seen = 0;
      for (int c = 0; c < cycles; c++)
      begin
         @(negedge rx_lclk);
         if (pkt_valid)
            seen++;
      end
      if (seen != 0)
      begin
         $display("pkt_valid rose while the receiver was disabled");
         tb_errors++;
      end
   endtask

   //######################################
   //# background processes
   //######################################
   initial
   begin : ready_drive
      pkt_ready = 1'b0;
      rcyc      = 3'd0;
      forever
      begin
         @(posedge rx_lclk);
         #1;
         pkt_ready = ready_pat[rcyc];
         rcyc      = rcyc + 3'd1;
      end
   end

   always @(negedge rx_lclk)
   begin
      if (load_taps)
         load_cycles++;                    // pulse width in cycles
   end

   initial
   begin : watchdog
      repeat (WATCHDOG) @(posedge rx_lclk);
      $display("run exceeded %0d cycles, stopping", WATCHDOG);
      $display("Simulation failed");
      $finish;
   end

   //######################################
   //# main sequence
   //######################################
   initial
   begin : main
      logic [31:0] rd;
      logic [31:0] lo;
      logic [31:0] hi;
      logic        exp_wait;
      int          base;
      erx_packet_u p;
      rx_frame  = 1'b0;
      rx_word   = 16'h0;
      awaddr    = 32'h0;
      awvalid   = 1'b0;
      wdata     = 32'h0;
      wstrb     = 4'h0;
      wvalid    = 1'b0;
      bready    = 1'b1;                    // responses always taken
      araddr    = 32'h0;
      arvalid   = 1'b0;
      rready    = 1'b1;
      rng_state = 32'd21142;
      wait_reset();

      // enable still 0 after reset, link traffic ignored
      for (int k = 0; k < 7; k++)
      begin
         next_random(rd);
         frame_words.push_back(rd[15:0]);
      end
      drive_frame();
      watch_no_valid(12);
      axi_read(REG_RXCNT, rd);
      check_value("REG_RXCNT", 64'h0, 64'(rd));

      // single and burst frames, one table entry at a time
      axi_write(REG_CFG, 32'h1);
      for (int i = 0; i < N_ENT; i++)
      begin
         ready_pat = tab_ready[i];
         load_entry(i);
         drive_frame();
         wait_drained();
      end

      // output stalled, fifo fills, wait rises, overflow drops
      ready_pat = 8'h00;
      for (int i = 1; i <= N_FLOOD; i++)
      begin
         random_header(p);
         next_random(rd);
         p.f.data = rd;
         next_random(rd);
         p.f.srcaddr = rd;
         queue_words(p, 1'b0);
         if (i <= FIFO_DEPTH)
         begin
            u_chk.expect_pkt(p.raw, 1'b0);
            sent++;
         end
         pushed++;
         drive_frame();
         repeat (2) @(posedge rx_lclk);    // push lands in the fifo
         #1;
         exp_wait = (((i < FIFO_DEPTH) ? i : FIFO_DEPTH) >= WAIT_LEVEL);
         check_value("rx_wr_wait", 64'(exp_wait), 64'(rx_wr_wait));
      end
      axi_read(REG_DROPCNT, rd);
      check_value("REG_DROPCNT", 64'(N_FLOOD - FIFO_DEPTH), 64'(rd));
      ready_pat = 8'hFF;
      wait_drained();
      @(posedge rx_lclk);
      #1;
      check_value("rx_wr_wait", 64'h0, 64'(rx_wr_wait));

      // delay taps, load pulse, unmapped read
      next_random(lo);
      next_random(hi);
      axi_write(REG_TAPLO, lo);
      axi_write(REG_TAPHI, hi);
      @(posedge rx_lclk);
      #1;
      check_value("idelay_value", 64'({hi[12:0], lo}), 64'(idelay_value));
      axi_read(REG_TAPHI, rd);
      check_value("REG_TAPHI", 64'({19'b0, hi[12:0]}), 64'(rd));
      check_value("load_taps cycles", 64'h0, 64'(load_cycles));   // none yet
      base = load_cycles;
      axi_write(REG_CFG, 32'h3);
      repeat (3) @(posedge rx_lclk);
      check_value("load_taps cycles", 64'h1, 64'(load_cycles - base));
      axi_read(REG_CFG, rd);
      check_value("REG_CFG", 64'h1, 64'(rd));
      axi_read(32'h0000_0020, rd);
      check_value("rdata unmapped", 64'h0, 64'(rd));
      axi_read(REG_RXCNT, rd);
      check_value("REG_RXCNT", 64'(pushed), 64'(rd));

      if (u_chk.pending() != 0)
      begin
         $display("%0d expected packets never came out", u_chk.pending());
         tb_errors++;
      end
      $display("errors: checker %0d, testbench %0d", u_chk.errors, tb_errors);
      if (u_chk.errors == 0 && tb_errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
